// ==== all.f ====
+incdir+rtl
rtl/alut_mem_pkg.sv
rtl/alut_host_pkg.sv
rtl/alut_mem.sv
rtl/alut_age_checker.sv
rtl/alut_addr_checker.sv
rtl/alut_ctrl.sv
rtl/alut_top.sv
sim/alut_scoreboard.sv
sim/alut_tb.sv

// ==== rtl/alut_addr_checker.sv ====
// alut address checker
// hashes the mac to a table index, writes learned entries and runs
// lookups through read, match test and an age query

`timescale 1ns/10ps
`include "alut_settings.svh"

module alut_addr_checker
   import alut_mem_pkg::*;
(
   input  logic                     pclk14,
   input  logic                     n_p_reset14,
   input  logic                     addr_start,
   input  logic                     is_learn,      // else lookup
   input  logic [`ALUT_MAC_W-1:0]   mac,           // held by ctrl for the whole op
   input  logic [`ALUT_PORT_W-1:0]  port,
   input  logic [`ALUT_TIME_W-1:0]  curr_time,
   output logic                     addr_done,
   output logic                     hit,
   output logic [`ALUT_PORT_W-1:0]  hit_port,
   output alut_age_query_t          query,
   input  logic                     age_confirmed,
   input  logic                     age_ok,
   output alut_mem_req_t            mem_req,
   input  logic                     mem_gnt,
   input  alut_entry_t              rdata
);

   typedef enum logic [2:0] {A_IDLE, A_WR, A_RD, A_DATA, A_AGE, A_DONE} addr_st_e;

   addr_st_e                st;
   alut_entry_t             ent_q;    // entry read by a lookup
   logic [`ALUT_IDX_W-1:0]  idx;

   // low mac byte xor second byte
   assign idx = mac[`ALUT_IDX_W-1:0] ^ mac[2*`ALUT_IDX_W-1:`ALUT_IDX_W];

   // ----------------------------------------
   // sequencing
   // ----------------------------------------
   always_ff @(posedge pclk14 or negedge n_p_reset14)
   begin
      if (!n_p_reset14)
         st <= A_IDLE;
      else
      begin
         case (st)
            A_IDLE:
               if (addr_start)
                  st <= is_learn ? A_WR : A_RD;
            A_WR:
               if (mem_gnt)
                  st <= A_DONE;
            A_RD:
               if (mem_gnt)
                  st <= A_DATA;      // retry while the table is busy
            A_DATA:
               st <= A_AGE;
            A_AGE:
               if (age_confirmed)
                  st <= A_IDLE;
            default:
               st <= A_IDLE;
         endcase
      end
   end

   // capture before a scan read can change rdata
   always_ff @(posedge pclk14)
   begin
      if (st == A_DATA)
         ent_q <= rdata;
   end

   // ----------------------------------------
   // memory access and age query
   // ----------------------------------------
   always_comb
   begin
      mem_req                 = '0;
      mem_req.en              = (st == A_WR || st == A_RD);
      mem_req.we              = (st == A_WR);
      mem_req.idx             = idx;
      mem_req.wdata.valid     = 1'b1;
      mem_req.wdata.last_time = curr_time;   // learn stamps the entry
      mem_req.wdata.port      = port;
      mem_req.wdata.mac       = mac;
   end

   assign query.check     = (st == A_AGE);
   assign query.last_time = ent_q.last_time;

   // learn ends in A_DONE, lookup ends on the age verdict
   assign addr_done = (st == A_DONE) || (st == A_AGE && age_confirmed);
   assign hit       = (st == A_AGE) && ent_q.valid && (ent_q.mac == mac) && age_ok;
   assign hit_port  = ent_q.port;

endmodule

// ==== rtl/alut_age_checker.sv ====
// alut age checker
// divided time base, invalidate scan FSM and one shared age comparison
// that answers address checker queries or judges scanned entries

`timescale 1ns/10ps
`include "alut_settings.svh"

module alut_age_checker
   import alut_mem_pkg::*, alut_host_pkg::*;
(
   input  logic                     pclk14,
   input  logic                     n_p_reset14,
   input  alut_cfg_t                cfg,
   input  logic                     age_start,
   input  logic                     age_cmd,         // set clears all, else aged only
   output logic                     age_done,
   input  alut_age_query_t          query,
   output logic                     age_confirmed,
   output logic                     age_ok,          // set means in date
   output logic [`ALUT_TIME_W-1:0]  curr_time,
   output alut_mem_req_t            mem_req,
   input  logic                     mem_gnt,
   input  alut_entry_t              rdata,
   output logic [`ALUT_MAC_W-1:0]   lst_inv_mac,
   output logic [`ALUT_PORT_W-1:0]  lst_inv_port,
   output logic                     inval_in_prog
);

   typedef enum logic [2:0] {S_IDLE, S_RD, S_CHK, S_WR, S_ALL, S_DONE} age_st_e;

   age_st_e                  st;
   logic [`ALUT_IDX_W-1:0]   scan_idx;
   logic [`ALUT_DIV_W-1:0]   div_cnt;
   logic [`ALUT_TIME_W-1:0]  cmp_time;
   logic [`ALUT_TIME_W-1:0]  elapsed;
   logic                     qry_slot;
   logic                     in_date;
   logic                     stale;

   // ----------------------------------------
   // time base
   // ----------------------------------------
   always_ff @(posedge pclk14 or negedge n_p_reset14)
   begin
      if (!n_p_reset14)
      begin
         div_cnt   <= '0;
         curr_time <= '0;
      end
      else if (div_cnt >= cfg.div_clk)   // >= also recovers when div_clk shrinks
      begin
         div_cnt   <= '0;
         curr_time <= curr_time + 1'b1;
      end
      else
         div_cnt <= div_cnt + 1'b1;
   end

   // ----------------------------------------
   // age comparison
   // ----------------------------------------
   // a query is taken only between scan steps
   assign qry_slot = query.check && !age_confirmed && (st == S_IDLE || st == S_RD);
   assign cmp_time = (st == S_CHK) ? rdata.last_time : query.last_time;
   assign elapsed  = curr_time - cmp_time;   // modulo subtract copes with counter wrap
   assign in_date  = cfg.best_bfr_age > elapsed;
   assign stale    = rdata.valid && !in_date;

   always_ff @(posedge pclk14 or negedge n_p_reset14)
   begin
      if (!n_p_reset14)
      begin
         age_confirmed <= 1'b0;
         age_ok        <= 1'b0;
      end
      else
      begin
         age_confirmed <= qry_slot;   // one cycle pulse per query
         age_ok        <= qry_slot && in_date;
      end
   end

   // ----------------------------------------
   // invalidate scan FSM
   // ----------------------------------------
   always_ff @(posedge pclk14 or negedge n_p_reset14)
   begin
      if (!n_p_reset14)
      begin
         st       <= S_IDLE;
         scan_idx <= '0;
      end
      else
      begin
         case (st)
            S_IDLE:
               if (age_start)
               begin
                  scan_idx <= '0;
                  st       <= age_cmd ? S_ALL : S_RD;
               end
            S_RD:
               if (mem_gnt)
                  st <= S_CHK;         // data arrives the cycle after the grant
            S_CHK:
               if (stale)
                  st <= S_WR;
               else if (&scan_idx)     // last index reached
                  st <= S_DONE;
               else
               begin
                  scan_idx <= scan_idx + 1'b1;
                  st       <= S_RD;
               end
            S_WR, S_ALL:
               if (mem_gnt)
               begin
                  if (&scan_idx)
                     st <= S_DONE;
                  else
                  begin
                     scan_idx <= scan_idx + 1'b1;
                     st       <= (st == S_WR) ? S_RD : S_ALL;
                  end
               end
            default:
               st <= S_IDLE;           // S_DONE lasts one cycle
         endcase
      end
   end

   assign age_done = (st == S_DONE);

   always_comb
   begin
      mem_req     = '0;                // zero wdata clears an entry
      mem_req.idx = scan_idx;
      mem_req.en  = (st == S_RD && !qry_slot) || st == S_WR || st == S_ALL;
      mem_req.we  = (st == S_WR || st == S_ALL);
   end

   // raised by the first cleared entry and dropped as the scan finishes
   always_ff @(posedge pclk14 or negedge n_p_reset14)
   begin
      if (!n_p_reset14)
         inval_in_prog <= 1'b0;
      else if (st == S_WR && mem_gnt)
         inval_in_prog <= 1'b1;
      else if (st == S_DONE)
         inval_in_prog <= 1'b0;
   end

   always_ff @(posedge pclk14 or negedge n_p_reset14)
   begin
      if (!n_p_reset14)
      begin
         lst_inv_mac  <= '0;
         lst_inv_port <= '0;
      end
      else if (st == S_CHK && stale)   // entry about to be cleared
      begin
         lst_inv_mac  <= rdata.mac;
         lst_inv_port <= rdata.port;
      end
   end

   // the address checker keeps its query raised through the confirm cycle
   a_confirm_has_query: assert property (@(posedge pclk14) disable iff (!n_p_reset14)
      age_confirmed |-> query.check);

endmodule

// ==== rtl/alut_ctrl.sv ====
// alut controller
// four phase host handshake, config register, op dispatch
// and response capture

`timescale 1ns/10ps
`include "alut_settings.svh"

module alut_ctrl
   import alut_host_pkg::*;
(
   input  logic                     pclk14,
   input  logic                     n_p_reset14,
   input  logic                     req,
   input  alut_req_t                req_data,      // stable while req is high
   output logic                     ack,
   output alut_resp_t               resp,
   output alut_cfg_t                cfg,
   output logic                     addr_start,
   output logic                     is_learn,
   output logic [`ALUT_MAC_W-1:0]   mac,
   output logic [`ALUT_PORT_W-1:0]  port,
   input  logic                     addr_done,
   input  logic                     hit,
   input  logic [`ALUT_PORT_W-1:0]  hit_port,
   output logic                     age_start,
   output logic                     age_cmd,
   input  logic                     age_done,
   input  logic [`ALUT_MAC_W-1:0]   lst_inv_mac,
   input  logic [`ALUT_PORT_W-1:0]  lst_inv_port,
   input  logic                     inval_in_prog
);

   typedef enum logic [1:0] {C_IDLE, C_BUSY, C_ACK} ctrl_st_e;

   ctrl_st_e  st;
   logic      accept;     // new request seen with ack low
   logic      to_addr;    // learn or lookup
   logic      to_age;     // either invalidate

   assign accept   = (st == C_IDLE) && req;
   assign to_addr  = (req_data.op == op_learn) || (req_data.op == op_lookup);
   assign to_age   = (req_data.op == op_inval_aged) || (req_data.op == op_inval_all);

   assign ack      = (st == C_ACK);
   assign is_learn = (req_data.op == op_learn);
   assign age_cmd  = (req_data.op == op_inval_all);
   assign mac      = req_data.mac;
   assign port     = req_data.port;

   // ----------------------------------------
   // handshake FSM
   // ----------------------------------------
   always_ff @(posedge pclk14 or negedge n_p_reset14)
   begin
      if (!n_p_reset14)
      begin
         st         <= C_IDLE;
         addr_start <= 1'b0;
         age_start  <= 1'b0;
         cfg        <= '{div_clk: '0, best_bfr_age: '1};   // never aged until set
         resp       <= '0;
      end
      else
      begin
         addr_start <= accept && to_addr;   // one cycle pulses
         age_start  <= accept && to_age;
         case (st)
            C_IDLE:
               if (req)
               begin
                  st <= (to_addr || to_age) ? C_BUSY : C_ACK;
                  if (req_data.op == op_set_config)
                     cfg <= '{div_clk: req_data.div_clk, best_bfr_age: req_data.best_bfr_age};
               end
            C_BUSY:
               if (addr_done || age_done)
               begin
                  st                <= C_ACK;
                  resp.hit          <= addr_done && hit;
                  resp.port         <= (addr_done && hit) ? hit_port : '0;
                  resp.lst_inv_mac  <= lst_inv_mac;
                  resp.lst_inv_port <= lst_inv_port;
                  resp.inval_seen   <= age_done && inval_in_prog;
               end
            C_ACK:
               if (!req)
                  st <= C_IDLE;         // ack drops next cycle
            default:
               st <= C_IDLE;
         endcase
      end
   end

   // host keeps req up until the op is acknowledged
   a_req_held: assert property (@(posedge pclk14) disable iff (!n_p_reset14)
      $fell(req) |-> ack);

endmodule

// ==== rtl/alut_host_pkg.sv ====
// alut host types
// operation codes, request and response payloads and the live config

`include "alut_settings.svh"

package alut_host_pkg;

   typedef enum logic [2:0] {
      op_learn      = 3'd0,   // store mac and port with current time
      op_lookup     = 3'd1,   // return port if valid, matching and in date
      op_inval_aged = 3'd2,   // clear every out of date entry
      op_inval_all  = 3'd3,   // clear the whole table
      op_set_config = 3'd4    // load divider and best before age
   } alut_op_e;

   typedef struct packed {
      alut_op_e                 op;
      logic [`ALUT_MAC_W-1:0]   mac;
      logic [`ALUT_PORT_W-1:0]  port;
      logic [`ALUT_DIV_W-1:0]   div_clk;
      logic [`ALUT_TIME_W-1:0]  best_bfr_age;
   } alut_req_t;

   typedef struct packed {
      logic                     hit;
      logic [`ALUT_PORT_W-1:0]  port;          // zero on a miss
      logic [`ALUT_MAC_W-1:0]   lst_inv_mac;   // last entry cleared by an aged scan
      logic [`ALUT_PORT_W-1:0]  lst_inv_port;
      logic                     inval_seen;    // aged scan cleared something
   } alut_resp_t;

   typedef struct packed {
      logic [`ALUT_DIV_W-1:0]   div_clk;       // time base ticks every div_clk+1 cycles
      logic [`ALUT_TIME_W-1:0]  best_bfr_age;
   } alut_cfg_t;

endpackage

// ==== rtl/alut_mem.sv ====
// alut table memory
// 256 entries, one registered read port shared by two clients,
// address checker has priority over the age checker

`timescale 1ns/10ps
`include "alut_settings.svh"

module alut_mem
   import alut_mem_pkg::*;
(
   input  logic          pclk14,
   input  logic          n_p_reset14,
   input  alut_mem_req_t addr_req,    // address checker, high priority
   input  alut_mem_req_t age_req,     // age checker scan
   output logic          addr_gnt,
   output logic          age_gnt,
   output alut_entry_t   rdata        // one cycle after an accepted read
);

   alut_entry_t             ram [`ALUT_DEPTH];   // payload storage
   logic [`ALUT_DEPTH-1:0]  vld;                 // valid flags, cleared by reset
   alut_entry_t             rd_q;
   logic                    rd_vld;
   alut_mem_req_t           sel;                 // winning access

   // fixed priority, loser retries
   assign addr_gnt = addr_req.en;
   assign age_gnt  = age_req.en & ~addr_req.en;
   assign sel      = addr_req.en ? addr_req : age_req;

   always_ff @(posedge pclk14)
   begin
      if (sel.en)
      begin
         if (sel.we)
            ram[sel.idx] <= sel.wdata;
         else
            rd_q <= ram[sel.idx];
      end
   end

   // valid bits live beside the ram so an empty table reads as invalid
   always_ff @(posedge pclk14 or negedge n_p_reset14)
   begin
      if (!n_p_reset14)
      begin
         vld    <= '0;
         rd_vld <= 1'b0;
      end
      else if (sel.en)
      begin
         if (sel.we)
            vld[sel.idx] <= sel.wdata.valid;
         else
            rd_vld <= vld[sel.idx];
      end
   end

   always_comb
   begin
      rdata       = rd_q;
      rdata.valid = rd_vld;   // flag array overrides the stored copy
   end

   // both clients must qualify a write with an enable
   a_we_needs_en: assert property (@(posedge pclk14) disable iff (!n_p_reset14)
      !(addr_req.we && !addr_req.en) && !(age_req.we && !age_req.en));

endmodule

// ==== rtl/alut_mem_pkg.sv ====
// alut storage types
// one table word, one memory access and the age query between checkers

`include "alut_settings.svh"

package alut_mem_pkg;

   // ----------------------------------------
   // table word, 83 bits
   // ----------------------------------------
   typedef struct packed {
      logic                     valid;      // entry holds a learned mac
      logic [`ALUT_TIME_W-1:0]  last_time;  // stamp from the last learn
      logic [`ALUT_PORT_W-1:0]  port;
      logic [`ALUT_MAC_W-1:0]   mac;
   } alut_entry_t;

   // one client access to the table
   typedef struct packed {
      logic                     en;         // access this cycle
      logic                     we;         // write when set, else read
      logic [`ALUT_IDX_W-1:0]   idx;
      alut_entry_t              wdata;
   } alut_mem_req_t;

   // in-date question from the address checker
   typedef struct packed {
      logic                     check;      // held until age_confirmed
      logic [`ALUT_TIME_W-1:0]  last_time;
   } alut_age_query_t;

endpackage

// ==== rtl/alut_settings.svh ====
// alut settings
// table geometry and field widths shared by the packages and RTL

`ifndef ALUT_SETTINGS_SVH
`define ALUT_SETTINGS_SVH

// table geometry
`define ALUT_DEPTH   256   // number of entries
`define ALUT_IDX_W   8     // entry index width, log2 of depth

// field widths
`define ALUT_MAC_W   48    // mac address
`define ALUT_PORT_W  2     // four switch ports
`define ALUT_TIME_W  32    // timestamp and age
`define ALUT_DIV_W   8     // time base divider

`endif

// ==== rtl/alut_top.sv ====
// alut top
// controller, address checker, age checker and table memory

`timescale 1ns/10ps
`include "alut_settings.svh"

module alut_top
   import alut_mem_pkg::*, alut_host_pkg::*;
(
   input  logic        pclk14,
   input  logic        n_p_reset14,
   input  logic        req,
   input  alut_req_t   req_data,
   output logic        ack,
   output alut_resp_t  resp
);

   alut_cfg_t                cfg;
   logic                     addr_start, is_learn, addr_done, hit;
   logic                     age_start, age_cmd, age_done, inval_in_prog;
   logic                     age_confirmed, age_ok, addr_gnt, age_gnt;
   logic [`ALUT_MAC_W-1:0]   mac, lst_inv_mac;
   logic [`ALUT_PORT_W-1:0]  port, hit_port, lst_inv_port;
   logic [`ALUT_TIME_W-1:0]  curr_time;
   alut_age_query_t          query;
   alut_mem_req_t            addr_mem_req, age_mem_req;
   alut_entry_t              rdata;

   alut_ctrl i_ctrl (
      .pclk14(pclk14), .n_p_reset14(n_p_reset14), .req(req), .req_data(req_data),
      .ack(ack), .resp(resp), .cfg(cfg), .addr_start(addr_start), .is_learn(is_learn),
      .mac(mac), .port(port), .addr_done(addr_done), .hit(hit), .hit_port(hit_port),
      .age_start(age_start), .age_cmd(age_cmd), .age_done(age_done),
      .lst_inv_mac(lst_inv_mac), .lst_inv_port(lst_inv_port), .inval_in_prog(inval_in_prog)
   );

   alut_addr_checker i_addr_checker (
      .pclk14(pclk14), .n_p_reset14(n_p_reset14), .addr_start(addr_start),
      .is_learn(is_learn), .mac(mac), .port(port), .curr_time(curr_time),
      .addr_done(addr_done), .hit(hit), .hit_port(hit_port), .query(query),
      .age_confirmed(age_confirmed), .age_ok(age_ok), .mem_req(addr_mem_req),
      .mem_gnt(addr_gnt), .rdata(rdata)
   );

   alut_age_checker i_age_checker (
      .pclk14(pclk14), .n_p_reset14(n_p_reset14), .cfg(cfg), .age_start(age_start),
      .age_cmd(age_cmd), .age_done(age_done), .query(query),
      .age_confirmed(age_confirmed), .age_ok(age_ok), .curr_time(curr_time),
      .mem_req(age_mem_req), .mem_gnt(age_gnt), .rdata(rdata),
      .lst_inv_mac(lst_inv_mac), .lst_inv_port(lst_inv_port), .inval_in_prog(inval_in_prog)
   );

   alut_mem i_mem (
      .pclk14(pclk14), .n_p_reset14(n_p_reset14), .addr_req(addr_mem_req),
      .age_req(age_mem_req), .addr_gnt(addr_gnt), .age_gnt(age_gnt), .rdata(rdata)
   );

endmodule

// ==== sim/alut_scoreboard.sv ====
// alut scoreboard
// follows each host transaction, keeps a reference table model
// and compares every response with the model and with the test file

`timescale 1ns/10ps
`include "alut_settings.svh"

module alut_scoreboard
   import alut_mem_pkg::*, alut_host_pkg::*;
(
   input  logic        pclk14,
   input  logic        n_p_reset14,
   input  logic        req,
   input  alut_req_t   req_data,
   input  logic        ack,
   input  alut_resp_t  resp,
   input  alut_resp_t  file_resp,   // expected response as listed in the test file
   output int          n_tests,
   output int          n_errors
);

   alut_entry_t              model [`ALUT_DEPTH];   // reference table
   alut_req_t                cur_req;
   alut_resp_t               cur_file;
   alut_resp_t               last_resp;             // dut holds resp across config ops
   logic [`ALUT_TIME_W-1:0]  best;
   logic [`ALUT_MAC_W-1:0]   lst_mac;
   logic [`ALUT_PORT_W-1:0]  lst_port;
   logic                     req_q, ack_q;

   // ----------------------------------------
   // reference rules
   // ----------------------------------------
   function automatic logic [`ALUT_IDX_W-1:0] hash_idx(input logic [`ALUT_MAC_W-1:0] m);
      return m[7:0] ^ m[15:8];   // low byte xor second byte
   endfunction

   // elapsed time stays far below all ones, so only a best-before of 0 ages
   function automatic logic fresh(input logic [`ALUT_TIME_W-1:0] b);
      return b != '0;
   endfunction

   function automatic string op_text(input alut_op_e op);
      case (op)
         op_learn:      return "learn";
         op_lookup:     return "lookup";
         op_inval_aged: return "inval_aged";
         op_inval_all:  return "inval_all";
         op_set_config: return "set_config";
         default:       return "unknown op";
      endcase
   endfunction

   function automatic string resp_text(input alut_resp_t r);
      return $sformatf("hit %b port %0d lst %h/%0d seen %b",
                       r.hit, r.port, r.lst_inv_mac, r.lst_inv_port, r.inval_seen);
   endfunction

   // apply one op to the model and predict the response
   task automatic apply_op(input alut_req_t rq, output alut_resp_t exp);
      logic [`ALUT_IDX_W-1:0] idx;
      logic                   seen;
      idx  = hash_idx(rq.mac);
      seen = 1'b0;
      exp  = '0;
      case (rq.op)
         op_learn:
            model[idx] = '{valid: 1'b1, last_time: '0, port: rq.port, mac: rq.mac};
         op_lookup:
            if (model[idx].valid && model[idx].mac == rq.mac && fresh(best))
            begin
               exp.hit  = 1'b1;
               exp.port = model[idx].port;
            end
         op_inval_aged:
            foreach (model[i])          // ascending, so the highest index wins
               if (model[i].valid && !fresh(best))
               begin
                  lst_mac        = model[i].mac;
                  lst_port       = model[i].port;
                  model[i].valid = 1'b0;
                  seen           = 1'b1;
               end
         op_inval_all:
            foreach (model[i])
               model[i].valid = 1'b0;
         default:
            ;                           // config and unknown ops handled below
      endcase
      exp.lst_inv_mac  = lst_mac;
      exp.lst_inv_port = lst_port;
      exp.inval_seen   = seen;
      if (rq.op == op_set_config)
         best = rq.best_bfr_age;
      if (rq.op != op_learn && rq.op != op_lookup && rq.op != op_inval_aged &&
          rq.op != op_inval_all)
         exp = last_resp;             // no checker runs, previous resp stays
      last_resp = exp;
   endtask

   task automatic check_resp();
      alut_resp_t exp;
      logic       good;
      apply_op(cur_req, exp);
      good = 1'b1;
      n_tests++;
      if (resp !== exp)
      begin
         good = 1'b0;
         $display("** Error @ %0t: test %0d %s, DUT %s, model %s", $time, n_tests,
                  op_text(cur_req.op), resp_text(resp), resp_text(exp));
      end
      if (resp !== cur_file)
      begin
         good = 1'b0;
         $display("** Error @ %0t: test %0d %s, DUT %s, file %s", $time, n_tests,
                  op_text(cur_req.op), resp_text(resp), resp_text(cur_file));
      end
      if (!good)
         n_errors++;
      $display("test %0d %s %s", n_tests, op_text(cur_req.op), good ? "ok" : "mismatch");
   endtask

   // ----------------------------------------
   // transaction tracking
   // ----------------------------------------
   always @(posedge pclk14 or negedge n_p_reset14)
   begin
      if (!n_p_reset14)
      begin
         foreach (model[i])
            model[i] = '0;
         best      = '1;          // config starts as never aged
         lst_mac   = '0;
         lst_port  = '0;
         last_resp = '0;
         req_q     = 1'b0;
         ack_q     = 1'b0;
         n_tests   = 0;
         n_errors  = 0;
      end
      else
      begin
         if (req && !req_q)       // new request, payload is stable
         begin
            cur_req  = req_data;
            cur_file = file_resp;
         end
         if (ack && !ack_q)       // response valid with the ack
            check_resp();
         req_q = req;
         ack_q = ack;
      end
   end

endmodule

// ==== sim/alut_tb.sv ====
// alut testbench
// reads operations from the test file, runs each as a four phase
// handshake on the DUT and leaves the checking to the scoreboard

`timescale 1ns/10ps
`include "alut_settings.svh"

module alut_tb
   import alut_host_pkg::*;
();

   logic        pclk14;
   logic        n_p_reset14;
   logic        req;
   logic        ack;
   alut_req_t   req_data;
   alut_resp_t  resp;
   alut_resp_t  file_resp;   // expected response of the current line
   int          n_tests;
   int          n_errors;
   alut_req_t   tst_req [$];
   alut_resp_t  tst_resp [$];

   alut_top i_alut_top (
      .pclk14(pclk14), .n_p_reset14(n_p_reset14), .req(req), .req_data(req_data),
      .ack(ack), .resp(resp)
   );

   alut_scoreboard i_scoreboard (
      .pclk14(pclk14), .n_p_reset14(n_p_reset14), .req(req), .req_data(req_data),
      .ack(ack), .resp(resp), .file_resp(file_resp), .n_tests(n_tests),
      .n_errors(n_errors)
   );

   initial
   begin
      pclk14 = 1'b0;
      forever #5 pclk14 = ~pclk14;   // 10 ns period
   end

   // ----------------------------------------
   // test file
   // ----------------------------------------
   task automatic load_tests(output logic ok);
      int                       fd;
      int                       n;
      string                    line;
      logic [3:0]               op;
      logic [`ALUT_MAC_W-1:0]   mac, lmac;
      logic [`ALUT_PORT_W-1:0]  port, hport, lport;
      logic [`ALUT_DIV_W-1:0]   div;
      logic [`ALUT_TIME_W-1:0]  best;
      logic                     hit, seen;
      ok = 1'b1;
      fd = $fopen("sim/alut_tests.txt", "r");
      if (fd == 0)
      begin
         $display("cannot open sim/alut_tests.txt");
         ok = 1'b0;
      end
      else
      begin
         while (!$feof(fd))
         begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 2 || line.getc(0) == "#")
               continue;                          // blank or column notes
            n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h",
                        op, mac, port, div, best, hit, hport, lmac, lport, seen);
            if (n != 10)
            begin
               $display("malformed test line: %s", line);
               ok = 1'b0;
            end
            else
            begin
               tst_req.push_back('{op: alut_op_e'(op[2:0]), mac: mac, port: port,
                                   div_clk: div, best_bfr_age: best});
               tst_resp.push_back('{hit: hit, port: hport, lst_inv_mac: lmac,
                                    lst_inv_port: lport, inval_seen: seen});
            end
         end
         $fclose(fd);
         if (tst_req.size() == 0)
         begin
            $display("test file holds no operations");
            ok = 1'b0;
         end
      end
   endtask

   // one four phase transaction, inputs move 1 ns after the edge
   task automatic run_op(input alut_req_t rq, input alut_resp_t rs);
      @(posedge pclk14);
      #1;
      req_data  = rq;
      file_resp = rs;
      req       = 1'b1;
      do
      begin
         @(posedge pclk14);
         #1;
      end
      while (!ack);
      req = 1'b0;
      do
      begin
         @(posedge pclk14);
         #1;
      end
      while (ack);                 // next request only after ack drops
   endtask

   // ----------------------------------------
   // main sequence
   // ----------------------------------------
   initial
   begin
      logic loaded;
      n_p_reset14 = 1'b0;
      req         = 1'b0;
      req_data    = '0;
      file_resp   = '0;
      load_tests(loaded);
      if (!loaded)
      begin
         $display("no tests run, the test file could not be used");
         $display("TB FAILED");
         $finish;
      end
      else
      begin
         fork
            begin                  // watchdog, 600 cycles per line
               repeat (tst_req.size() * 600) @(posedge pclk14);
               $display("timeout: tests did not finish in %0d cycles",
                        tst_req.size() * 600);
               $display("TB FAILED");
               $finish;
            end
         join_none
         repeat (3) @(posedge pclk14);
         #1;
         n_p_reset14 = 1'b1;
         foreach (tst_req[i])
            run_op(tst_req[i], tst_resp[i]);
         repeat (2) @(posedge pclk14);
         $display("tests %0d of %0d checked, errors %0d", n_tests, tst_req.size(), n_errors);
         if (n_errors == 0 && n_tests == tst_req.size())
            $display("TB PASSED");
         else
            $display("TB FAILED");
         $finish;
      end
   end

endmodule

// ==== sim/alut_tests.txt ====
# op mac port div_clk best_bfr_age | hit hit_port lst_inv_mac lst_inv_port inval_seen
# op: 0 learn, 1 lookup, 2 inval aged, 3 inval all, 4 set config; all fields hex
4 000000000000 0 03 ffffffff 0 0 000000000000 0 0
0 000011112233 1 00 00000000 0 0 000000000000 0 0
1 000011112233 0 00 00000000 1 1 000000000000 0 0
1 0000aaaa0102 0 00 00000000 0 0 000000000000 0 0
0 0a0b0c0d0e0f 2 00 00000000 0 0 000000000000 0 0
0 1234567800ff 3 00 00000000 0 0 000000000000 0 0
1 0a0b0c0d0e0f 0 00 00000000 1 2 000000000000 0 0
1 1234567800ff 0 00 00000000 1 3 000000000000 0 0
0 000000001020 0 00 00000000 0 0 000000000000 0 0
0 000000002010 2 00 00000000 0 0 000000000000 0 0
1 000000001020 0 00 00000000 0 0 000000000000 0 0
1 000000002010 0 00 00000000 1 2 000000000000 0 0
2 000000000000 0 00 00000000 0 0 000000000000 0 0
1 000011112233 0 00 00000000 1 1 000000000000 0 0
4 000000000000 0 00 00000000 1 1 000000000000 0 0
1 000011112233 0 00 00000000 0 0 000000000000 0 0
2 000000000000 0 00 00000000 0 0 1234567800ff 3 1
4 000000000000 0 00 ffffffff 0 0 1234567800ff 3 1
1 000011112233 0 00 00000000 0 0 1234567800ff 3 0
1 1234567800ff 0 00 00000000 0 0 1234567800ff 3 0
0 0000aaaa0102 3 00 00000000 0 0 1234567800ff 3 0
0 00000000beef 1 00 00000000 0 0 1234567800ff 3 0
1 0000aaaa0102 0 00 00000000 1 3 1234567800ff 3 0
3 000000000000 0 00 00000000 0 0 1234567800ff 3 0
1 0000aaaa0102 0 00 00000000 0 0 1234567800ff 3 0
1 00000000beef 0 00 00000000 0 0 1234567800ff 3 0
2 000000000000 0 00 00000000 0 0 1234567800ff 3 0
0 00000000beef 2 00 00000000 0 0 1234567800ff 3 0
1 00000000beef 0 00 00000000 1 2 1234567800ff 3 0
4 000000000000 0 01 00000000 1 2 1234567800ff 3 0
2 000000000000 0 00 00000000 0 0 00000000beef 2 1
4 000000000000 0 00 ffffffff 0 0 00000000beef 2 1
1 00000000beef 0 00 00000000 0 0 00000000beef 2 0
1 0a0b0c0d0e0f 0 00 00000000 0 0 00000000beef 2 0
